/* common/secmem_pkg.sv */
// secure data memory shared definitions
// field widths, payload types and request encoding used by every block

package secmem_pkg;

	//====================================================================
	// field widths
	//====================================================================

	localparam int c_addr_nbits   = 32;
	localparam int c_data_nbits   = 32;
	localparam int c_opaque_nbits = 8;

	// byte address to word index
	localparam int c_word_offset = 2;

	// one port per security domain, port index is the domain number
	localparam int c_num_ports = 2;

	//====================================================================
	// message fields
	//====================================================================

	// byte address of a request
	typedef logic [c_addr_nbits-1:0] addr_t;

	// write data and read data
	typedef logic [c_data_nbits-1:0] data_t;

	// requester tag, returned untouched in the response
	typedef logic [c_opaque_nbits-1:0] opaque_t;

	// request kind, same encoding as the memory messages
	typedef enum logic {
		c_req_read  = 1'b0,
		c_req_write = 1'b1
	} req_type_t;

endpackage

/* design/mem_ctrl/access_ctrl.sv */
`timescale 1ns/1ps
// memory access controller
// one request at a time: accept, check and access, then respond to its port

module access_ctrl #(
	parameter int p_mem_nwords = 256
) (
	input  logic clk,
	input  logic reset,

	// granted request
	input  logic grant_val,
	output logic grant_rdy,
	input  logic grant_port,
	input  secmem_pkg::req_type_t grant_type,
	input  secmem_pkg::opaque_t grant_opaque,
	input  secmem_pkg::addr_t grant_addr,
	input  secmem_pkg::data_t grant_data,

	// permission check
	output secmem_pkg::addr_t chk_addr,
	output logic chk_domain,
	input  logic allowed,

	// word memory
	output logic mem_wr_en,
	output logic mem_rd_en,
	output logic [$clog2(p_mem_nwords)-1:0] mem_index,
	output secmem_pkg::data_t mem_wdata,
	input  secmem_pkg::data_t mem_rdata,

	// domain 0 response
	output logic resp0_val,
	input  logic resp0_rdy,
	output secmem_pkg::req_type_t resp0_type,
	output secmem_pkg::opaque_t resp0_opaque,
	output logic resp0_ok,
	output secmem_pkg::data_t resp0_data,

	// domain 1 response
	output logic resp1_val,
	input  logic resp1_rdy,
	output secmem_pkg::req_type_t resp1_type,
	output secmem_pkg::opaque_t resp1_opaque,
	output logic resp1_ok,
	output secmem_pkg::data_t resp1_data
);

	localparam int c_index_nbits = $clog2(p_mem_nwords);

	typedef enum logic [1:0] {
		s_idle,
		s_access,
		s_respond
	} state_t;

	state_t state_q;

	// latched request
	logic req_port_q;
	secmem_pkg::req_type_t req_type_q;
	secmem_pkg::opaque_t req_opaque_q;
	secmem_pkg::addr_t req_addr_q;
	secmem_pkg::data_t req_data_q;

	// response registers
	logic ok_q;
	logic resp_val_q;
	secmem_pkg::data_t resp_data_q;

	secmem_pkg::addr_t word_addr;
	logic resp_rdy;
	logic is_read;

	//====================================================================
	// control FSM
	//====================================================================

	assign grant_rdy = (state_q == s_idle);
	assign resp_rdy  = req_port_q ? resp1_rdy : resp0_rdy;

	// respond spends its first cycle loading the output registers
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q    <= s_idle;
			resp_val_q <= 1'b0;
		end else begin
			case (state_q)
				s_idle: begin
					if (grant_val && grant_rdy) begin
						state_q <= s_access;
					end
				end
				s_access: begin
					state_q <= s_respond;
				end
				s_respond: begin
					if (!resp_val_q) begin
						resp_val_q <= 1'b1;
					end else if (resp_rdy) begin
						resp_val_q <= 1'b0;
						state_q    <= s_idle;
					end
				end
				default: begin
					state_q <= s_idle;
				end
			endcase
		end
	end

	//====================================================================
	// datapath
	//====================================================================

	always_ff @(posedge clk) begin
		if (grant_val && grant_rdy) begin
			req_port_q   <= grant_port;
			req_type_q   <= grant_type;
			req_opaque_q <= grant_opaque;
			req_addr_q   <= grant_addr;
			req_data_q   <= grant_data;
		end
		if (state_q == s_access) begin
			ok_q <= allowed;
		end
		// denied reads and all writes return zero
		if (state_q == s_respond && !resp_val_q) begin
			resp_data_q <= (is_read && ok_q) ? mem_rdata : '0;
		end
	end

	assign is_read = (req_type_q == secmem_pkg::c_req_read);

	// check runs on the latched request
	assign chk_addr   = req_addr_q;
	assign chk_domain = req_port_q;

	// word index wraps at the memory depth
	assign word_addr = req_addr_q >> secmem_pkg::c_word_offset;
	assign mem_index = c_index_nbits'(word_addr % p_mem_nwords);
	assign mem_wdata = req_data_q;

	// memory only touched when the domain owns the address
	assign mem_wr_en = (state_q == s_access) && !is_read && allowed;
	assign mem_rd_en = (state_q == s_access) && is_read && allowed;

	// steer the response to the requesting port
	assign resp0_val    = resp_val_q && (req_port_q == 1'b0);
	assign resp1_val    = resp_val_q && (req_port_q == 1'b1);
	assign resp0_type   = req_type_q;
	assign resp1_type   = req_type_q;
	assign resp0_opaque = req_opaque_q;
	assign resp1_opaque = req_opaque_q;
	assign resp0_ok     = ok_q;
	assign resp1_ok     = ok_q;
	assign resp0_data   = resp_data_q;
	assign resp1_data   = resp_data_q;

	// a stalled response keeps its val and payload
	a_resp0_hold: assert property (
		@(posedge clk) disable iff (reset)
		resp0_val && !resp0_rdy |=> resp0_val &&
			$stable({resp0_type, resp0_opaque, resp0_ok, resp0_data})
	);

	a_resp1_hold: assert property (
		@(posedge clk) disable iff (reset)
		resp1_val && !resp1_rdy |=> resp1_val &&
			$stable({resp1_type, resp1_opaque, resp1_ok, resp1_data})
	);

endmodule

/* design/mem_ctrl/partition_check.sv */
`timescale 1ns/1ps
// partition check
// holds the partition address and decides if a domain may touch an address

module partition_check #(
	parameter secmem_pkg::addr_t p_initial_par = 32'h200
) (
	input  logic clk,
	input  logic reset,

	// partition update
	input  logic par_en,
	input  secmem_pkg::addr_t par_addr,

	// access under check
	input  secmem_pkg::addr_t chk_addr,
	input  logic chk_domain,
	output logic allowed
);

	// first address owned by domain 1
	secmem_pkg::addr_t par_q;

	// new partition takes effect on the edge after par_en
	always_ff @(posedge clk) begin
		if (reset) begin
			par_q <= p_initial_par;
		end else if (par_en) begin
			par_q <= par_addr;
		end
	end

	// domain 0 below the partition, domain 1 at or above it
	always_comb begin
		if (chk_domain) begin
			allowed = (chk_addr >= par_q);
		end else begin
			allowed = (chk_addr < par_q);
		end
	end

endmodule

/* design/mem_net/req_arbiter.sv */
`timescale 1ns/1ps
// request arbiter
// round-robin merge of the two domain request ports onto one grant channel

module req_arbiter (
	input  logic clk,
	input  logic reset,

	// domain 0 request
	input  logic req0_val,
	output logic req0_rdy,
	input  secmem_pkg::req_type_t req0_type,
	input  secmem_pkg::opaque_t req0_opaque,
	input  secmem_pkg::addr_t req0_addr,
	input  secmem_pkg::data_t req0_data,

	// domain 1 request
	input  logic req1_val,
	output logic req1_rdy,
	input  secmem_pkg::req_type_t req1_type,
	input  secmem_pkg::opaque_t req1_opaque,
	input  secmem_pkg::addr_t req1_addr,
	input  secmem_pkg::data_t req1_data,

	// merged request
	output logic grant_val,
	input  logic grant_rdy,
	output logic grant_port,
	output secmem_pkg::req_type_t grant_type,
	output secmem_pkg::opaque_t grant_opaque,
	output secmem_pkg::addr_t grant_addr,
	output secmem_pkg::data_t grant_data
);

	// port served by the last transfer
	logic last_q;
	// port that wins a tie
	logic prio_port;

	assign prio_port = 1'((int'(last_q) + 1) % secmem_pkg::c_num_ports);

	// selection
	always_comb begin
		grant_val = req0_val || req1_val;
		if (req0_val && req1_val) begin
			grant_port = prio_port;
		end else begin
			grant_port = req1_val;
		end
	end

	// payload of the selected port
	assign grant_type   = grant_port ? req1_type : req0_type;
	assign grant_opaque = grant_port ? req1_opaque : req0_opaque;
	assign grant_addr   = grant_port ? req1_addr : req0_addr;
	assign grant_data   = grant_port ? req1_data : req0_data;

	// ready goes back to the selected port only
	assign req0_rdy = grant_rdy && (grant_port == 1'b0);
	assign req1_rdy = grant_rdy && (grant_port == 1'b1);

	// last served starts at the top port so port 0 wins first
	always_ff @(posedge clk) begin
		if (reset) begin
			last_q <= 1'(secmem_pkg::c_num_ports - 1);
		end else if (grant_val && grant_rdy) begin
			last_q <= grant_port;
		end
	end

	// a grant always points at a requesting port
	a_grant_has_req: assert property (
		@(posedge clk) disable iff (reset)
		grant_val |-> (grant_port ? req1_val : req0_val)
	);

endmodule

/* design/secmem_top.sv */
`timescale 1ns/1ps
// secure data memory top
// two domain ports share one word memory split by a movable partition

module secmem_top #(
	parameter int p_mem_nwords = 256,
	parameter secmem_pkg::addr_t p_initial_par = 32'h200
) (
	input  logic clk,
	input  logic reset,

	// domain 0 port
	input  logic req0_val,
	output logic req0_rdy,
	input  secmem_pkg::req_type_t req0_type,
	input  secmem_pkg::opaque_t req0_opaque,
	input  secmem_pkg::addr_t req0_addr,
	input  secmem_pkg::data_t req0_data,
	output logic resp0_val,
	input  logic resp0_rdy,
	output secmem_pkg::req_type_t resp0_type,
	output secmem_pkg::opaque_t resp0_opaque,
	output logic resp0_ok,
	output secmem_pkg::data_t resp0_data,

	// domain 1 port
	input  logic req1_val,
	output logic req1_rdy,
	input  secmem_pkg::req_type_t req1_type,
	input  secmem_pkg::opaque_t req1_opaque,
	input  secmem_pkg::addr_t req1_addr,
	input  secmem_pkg::data_t req1_data,
	output logic resp1_val,
	input  logic resp1_rdy,
	output secmem_pkg::req_type_t resp1_type,
	output secmem_pkg::opaque_t resp1_opaque,
	output logic resp1_ok,
	output secmem_pkg::data_t resp1_data,

	// partition update and memory clear
	input  logic par_en,
	input  secmem_pkg::addr_t par_addr,
	input  logic mem_clear
);

	//====================================================================
	// internal wires
	//====================================================================

	// arbiter to controller
	logic grant_val;
	logic grant_rdy;
	logic grant_port;
	secmem_pkg::req_type_t grant_type;
	secmem_pkg::opaque_t grant_opaque;
	secmem_pkg::addr_t grant_addr;
	secmem_pkg::data_t grant_data;

	// controller to partition check
	secmem_pkg::addr_t chk_addr;
	logic chk_domain;
	logic allowed;

	// controller to memory
	logic mem_wr_en;
	logic mem_rd_en;
	logic [$clog2(p_mem_nwords)-1:0] mem_index;
	secmem_pkg::data_t mem_wdata;
	secmem_pkg::data_t mem_rdata;

	//====================================================================
	// blocks, port names match the wires above
	//====================================================================

	req_arbiter u_arbiter (.*);

	access_ctrl #(
		.p_mem_nwords (p_mem_nwords)
	) u_ctrl (.*);

	partition_check #(
		.p_initial_par (p_initial_par)
	) u_partition (.*);

	word_mem #(
		.p_mem_nwords (p_mem_nwords)
	) u_mem (
		.clk       (clk),
		.mem_clear (mem_clear),
		.wr_en     (mem_wr_en),
		.rd_en     (mem_rd_en),
		.index     (mem_index),
		.wdata     (mem_wdata),
		.rdata     (mem_rdata)
	);

endmodule

/* design/word_mem.sv */
`timescale 1ns/1ps
// word memory
// registered read port, write on the edge, single-cycle clear of all words

module word_mem #(
	parameter int p_mem_nwords = 256
) (
	input  logic clk,
	input  logic mem_clear,
	input  logic wr_en,
	input  logic rd_en,
	input  logic [$clog2(p_mem_nwords)-1:0] index,
	input  secmem_pkg::data_t wdata,
	output secmem_pkg::data_t rdata
);

	secmem_pkg::data_t mem [p_mem_nwords];

	// contents are undefined until the first clear
	always_ff @(posedge clk) begin
		if (mem_clear) begin
			for (int i = 0; i < p_mem_nwords; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[index] <= wdata;
		end
	end

	// read word holds until the next read
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rdata <= mem[index];
		end
	end

	// clear is only driven with no request outstanding
	a_no_write_on_clear: assert property (
		@(posedge clk) !(wr_en && mem_clear)
	);

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the secure memory testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module secmem_tb -f secmem_top.f -o secmem_sim
out=$(./obj_dir/secmem_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1

/* secmem_top.f */
+incdir+sim
common/secmem_pkg.sv
design/mem_net/req_arbiter.sv
design/mem_ctrl/partition_check.sv
design/mem_ctrl/access_ctrl.sv
design/word_mem.sv
design/secmem_top.sv
sim/secmem_tb.sv

/* sim/secmem_ref.svh */
// secure memory reference model
// shadow memory and partition, expected responses, xorshift and value compare

`ifndef secmem_ref_svh
`define secmem_ref_svh

secmem_pkg::data_t shadow_mem [c_mem_nwords];
secmem_pkg::addr_t shadow_par = c_initial_par;
logic [31:0] rng_state = 32'd40;
int errors = 0;
int checks = 0;

function automatic logic [31:0] next_rand();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

// byte address to word slot, wrapping at the memory depth
function automatic int word_index(input secmem_pkg::addr_t addr);
	return int'((addr >> secmem_pkg::c_word_offset) % c_mem_nwords);
endfunction

// domain 0 owns the space below the partition, domain 1 the rest
function automatic logic domain_allowed(input logic domain, input secmem_pkg::addr_t addr);
	if (domain) begin
		return addr >= shadow_par;
	end
	return addr < shadow_par;
endfunction

// response as {type, opaque, ok, data}
function automatic logic [41:0] ref_response(input logic domain,
		input secmem_pkg::req_type_t kind, input secmem_pkg::opaque_t tag,
		input secmem_pkg::addr_t addr);
	logic ok;
	secmem_pkg::data_t word;
	ok = domain_allowed(domain, addr);
	word = '0;
	if (kind == secmem_pkg::c_req_read && ok) begin
		word = shadow_mem[word_index(addr)];
	end
	return {kind, tag, ok, word};
endfunction

task automatic check_equal(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
	checks++;
	if (expected !== actual) begin
		errors++;
		$display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
	end
endtask

`endif

/* sim/secmem_tb.sv */
`timescale 1ns/1ps
// secure memory testbench
// directed and random traffic on both domain ports against a reference model

module secmem_tb;

	localparam int c_mem_nwords = 256;
	localparam secmem_pkg::addr_t c_initial_par = 32'h200;
	localparam int c_num_directed = 21;
	localparam int c_num_random = 40;
	localparam int c_num_requests = c_num_directed + 2 * c_num_random;
	localparam int c_timeout = 4 * (c_num_requests * 6 + 200);

	`include "secmem_ref.svh"

	logic clk = 1'b0;
	logic reset;
	logic req0_val, req0_rdy, req1_val, req1_rdy;
	secmem_pkg::req_type_t req0_type, req1_type, resp0_type, resp1_type;
	secmem_pkg::opaque_t req0_opaque, req1_opaque, resp0_opaque, resp1_opaque;
	secmem_pkg::addr_t req0_addr, req1_addr, par_addr;
	secmem_pkg::data_t req0_data, req1_data, resp0_data, resp1_data;
	logic resp0_val, resp0_rdy, resp0_ok, resp1_val, resp1_rdy, resp1_ok;
	logic par_en, mem_clear;

	// scoreboard state
	logic [41:0] exp_q [2][$];
	int acc_q [2][$];
	logic seen [2] = '{1'b0, 1'b0};
	logic last_port = 1'b1;
	logic bp_on = 1'b0;
	int cycle = 0;
	string test_name = "reset";

	secmem_top #(
		.p_mem_nwords  (c_mem_nwords),
		.p_initial_par (c_initial_par)
	) dut (.*);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// response back-pressure
	always @(posedge clk) begin
		logic [31:0] r;
		#2;
		r = bp_on ? next_rand() : 32'hffff_ffff;
		resp0_rdy = r[0] | r[1];
		resp1_rdy = r[2] | r[3];
	end

	//======================================================================
	// scoreboard
	//======================================================================

	task automatic watch_port(input int p, input logic rv, input logic rr, input logic other_rv,
			input secmem_pkg::req_type_t kind, input secmem_pkg::opaque_t tag,
			input secmem_pkg::addr_t addr, input secmem_pkg::data_t data,
			input logic sv, input logic sr, input secmem_pkg::req_type_t s_kind,
			input secmem_pkg::opaque_t s_tag, input logic s_ok, input secmem_pkg::data_t s_data);
		logic [41:0] expected;
		// request transfers on the coming edge
		if (rv && rr) begin
			if (other_rv) begin
				check_equal($sformatf("%s arbiter order", test_name), 64'(!last_port), 64'(p));
			end
			last_port = 1'(p);
			expected = ref_response(1'(p), kind, tag, addr);
			if (kind == secmem_pkg::c_req_write && expected[32]) begin
				shadow_mem[word_index(addr)] = data;
			end
			exp_q[p].push_back(expected);
			acc_q[p].push_back(cycle + 1);
		end
		if (sv) begin
			if (exp_q[p].size() == 0) begin
				errors++;
				$display("port %0d raised a response with no request outstanding", p);
			end else begin
				if (!seen[p]) begin
					check_equal($sformatf("%s port%0d latency", test_name, p),
						64'(acc_q[p][0] + 2), 64'(cycle));
					seen[p] = 1'b1;
				end
				if (sr) begin
					check_equal($sformatf("%s port%0d response", test_name, p),
						64'(exp_q[p][0]), 64'({s_kind, s_tag, s_ok, s_data}));
					void'(exp_q[p].pop_front());
					void'(acc_q[p].pop_front());
					seen[p] = 1'b0;
				end
			end
		end
	endtask

	// mid-cycle sampling, values here are what the next edge sees
	always @(negedge clk) begin
		if (!reset) begin
			watch_port(0, req0_val, req0_rdy, req1_val, req0_type, req0_opaque, req0_addr,
				req0_data, resp0_val, resp0_rdy, resp0_type, resp0_opaque, resp0_ok, resp0_data);
			watch_port(1, req1_val, req1_rdy, req0_val, req1_type, req1_opaque, req1_addr,
				req1_data, resp1_val, resp1_rdy, resp1_type, resp1_opaque, resp1_ok, resp1_data);
		end
	end

	//======================================================================
	// stimulus tasks
	//======================================================================

	task automatic send_req(input int port, input secmem_pkg::req_type_t kind,
			input secmem_pkg::opaque_t tag, input secmem_pkg::addr_t addr,
			input secmem_pkg::data_t data);
		logic taken;
		@(posedge clk);
		#2;
		if (port == 0) begin
			req0_type = kind;
			req0_opaque = tag;
			req0_addr = addr;
			req0_data = data;
			req0_val = 1'b1;
		end else begin
			req1_type = kind;
			req1_opaque = tag;
			req1_addr = addr;
			req1_data = data;
			req1_val = 1'b1;
		end
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = (port == 0) ? req0_rdy : req1_rdy;
		end
		@(posedge clk);
		#2;
		if (port == 0) begin
			req0_val = 1'b0;
		end else begin
			req1_val = 1'b0;
		end
	endtask

	task automatic wait_idle();
		while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic set_partition(input secmem_pkg::addr_t addr);
		wait_idle();
		@(posedge clk);
		#2;
		par_en = 1'b1;
		par_addr = addr;
		shadow_par = addr;
		@(posedge clk);
		#2;
		par_en = 1'b0;
	endtask

	task automatic clear_memory();
		wait_idle();
		@(posedge clk);
		#2;
		mem_clear = 1'b1;
		@(posedge clk);
		#2;
		mem_clear = 1'b0;
		for (int i = 0; i < c_mem_nwords; i++) begin
			shadow_mem[i] = '0;
		end
	endtask

	task automatic random_traffic(input int port);
		logic [31:0] r;
		for (int i = 0; i < c_num_random; i++) begin
			r = next_rand();
			send_req(port, secmem_pkg::req_type_t'(r[0]), 8'(i), r & 32'h7ff, next_rand());
		end
	endtask

	task automatic finish_run();
		if (exp_q[0].size() + exp_q[1].size() != 0) begin
			errors++;
			$display("%0d expected responses never arrived", exp_q[0].size() + exp_q[1].size());
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	initial begin
		wait (cycle >= c_timeout);
		errors++;
		$display("timeout after %0d cycles, the run did not complete", cycle);
		finish_run();
	end

	//======================================================================
	// test sequence
	//======================================================================

	initial begin
		reset = 1'b1;
		req0_val = 1'b0;
		req0_type = secmem_pkg::c_req_read;
		req0_opaque = '0;
		req0_addr = '0;
		req0_data = '0;
		req1_val = 1'b0;
		req1_type = secmem_pkg::c_req_read;
		req1_opaque = '0;
		req1_addr = '0;
		req1_data = '0;
		resp0_rdy = 1'b1;
		resp1_rdy = 1'b1;
		par_en = 1'b0;
		par_addr = '0;
		mem_clear = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		check_equal("reset resp0_val", 64'(0), 64'(resp0_val));
		check_equal("reset resp1_val", 64'(0), 64'(resp1_val));
		clear_memory();

		test_name = "write read";
		send_req(0, secmem_pkg::c_req_write, 8'h11, 32'h40, 32'hcafe_0001);
		send_req(0, secmem_pkg::c_req_read, 8'h12, 32'h40, 32'h0);
		send_req(1, secmem_pkg::c_req_write, 8'h21, 32'h300, 32'hbeef_0002);
		send_req(1, secmem_pkg::c_req_read, 8'h22, 32'h300, 32'h0);

		// denied write must not disturb the owner's word
		test_name = "cross domain";
		send_req(0, secmem_pkg::c_req_write, 8'h31, 32'h300, 32'hdead_0003);
		send_req(0, secmem_pkg::c_req_read, 8'h32, 32'h300, 32'h0);
		send_req(1, secmem_pkg::c_req_read, 8'h33, 32'h300, 32'h0);
		send_req(1, secmem_pkg::c_req_write, 8'h34, 32'h40, 32'hdead_0004);
		send_req(0, secmem_pkg::c_req_read, 8'h35, 32'h40, 32'h0);

		test_name = "partition move";
		set_partition(32'h100);
		send_req(0, secmem_pkg::c_req_read, 8'h41, 32'h140, 32'h0);
		send_req(1, secmem_pkg::c_req_write, 8'h42, 32'h140, 32'h1234_5678);
		send_req(1, secmem_pkg::c_req_read, 8'h43, 32'h140, 32'h0);
		send_req(0, secmem_pkg::c_req_read, 8'h44, 32'h80, 32'h0);
		send_req(1, secmem_pkg::c_req_read, 8'h45, 32'h100, 32'h0);
		send_req(0, secmem_pkg::c_req_read, 8'h46, 32'h100, 32'h0);
		set_partition(c_initial_par);

		test_name = "random traffic";
		bp_on = 1'b1;
		fork
			random_traffic(0);
			random_traffic(1);
		join
		wait_idle();
		bp_on = 1'b0;

		test_name = "clear";
		clear_memory();
		send_req(0, secmem_pkg::c_req_read, 8'h61, 32'h0, 32'h0);
		send_req(0, secmem_pkg::c_req_read, 8'h62, 32'h40, 32'h0);
		send_req(0, secmem_pkg::c_req_read, 8'h63, 32'h1fc, 32'h0);
		send_req(1, secmem_pkg::c_req_read, 8'h64, 32'h200, 32'h0);
		send_req(1, secmem_pkg::c_req_read, 8'h65, 32'h300, 32'h0);
		send_req(1, secmem_pkg::c_req_read, 8'h66, 32'h3fc, 32'h0);
		wait_idle();
		repeat (5) @(posedge clk);
		finish_run();
	end

endmodule
